/* vlog.f */
rv32i_pkg.sv
ooo_pkg.sv
regfile.sv
dispatch.sv
res_station.sv
ro_buffer.sv
ooo_core.sv
ooo_properties.sv
tb_clk_gen.sv
tb_ooo_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_ooo_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

/* tb_ooo_core.sv */
`timescale 1ns/1ps

module tb_ooo_core;
    import ooo_pkg::*;
    import rv32i_pkg::*;

    localparam int num_instr  = 300;
    // core's default rob size including reserved slot 0
    localparam int rob_slots  = 8;
    localparam int max_cycles = num_instr * 20 + 200;

    logic        clk;
    logic        rst;
    logic        flush;
    logic        instr_valid;
    rv32_instr_t instr;
    logic        instr_ready;
    logic        commit_valid;
    tag_t        commit_tag;
    reg_idx_t    commit_rd;
    word_t       commit_value;

    // register state seen by issue order and by retirement
    logic [31:0] spec_regs      [32];
    logic [31:0] committed_regs [32];
    // outstanding results, oldest first
    logic [4:0]  exp_rd  [$];
    logic [31:0] exp_val [$];
    tag_t        exp_tag [$];
    tag_t        next_tag;
    integer      seed;
    int          errors;
    int          accepted;
    int          committed;
    int          dropped;
    int          x0_commits;
    int          stall_cycles;
    int          stalls_before;
    int          cycles = 0;

    tb_clk_gen #(
        .period_ns (20)
    ) i_clk_gen (
        .clk (clk)
    );

    ooo_core i_ooo_core (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_ready  (instr_ready),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    // kinds 0..5 are add sub and or xor slt and 6..10 the immediate forms
    function automatic logic [31:0] encode(input int kind, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [11:0] imm);
        logic [2:0] f3;
        logic [6:0] f7;
        case (kind)
            0, 1, 6: f3 = 3'b000;
            5, 10:   f3 = 3'b010;
            4, 9:    f3 = 3'b100;
            3, 8:    f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        f7 = (kind == 1) ? 7'b0100000 : 7'b0000000;
        if (kind >= 6) begin
            return {imm, rs1, f3, rd, 7'b0010011};
        end
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] alu_model(input int kind, input logic [31:0] a,
                                              input logic [31:0] b);
        case (kind)
            0, 6:    return a + b;
            1:       return a - b;
            2, 7:    return a & b;
            3, 8:    return a | b;
            4, 9:    return a ^ b;
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic check_commit();
        logic [4:0]  rd;
        logic [31:0] val;
        tag_t        tag;
        // every pulse counts, expected or not
        committed++;
        if (exp_rd.size() == 0) begin
            $display("commit of x%0d at %0t with no instruction outstanding", commit_rd, $time);
            errors++;
        end else begin
            rd  = exp_rd.pop_front();
            val = exp_val.pop_front();
            tag = exp_tag.pop_front();
            if (commit_rd !== rd) begin
                $display("CHECK FAILED at %0t: commit rd x%0d, expected x%0d",
                         $time, commit_rd, rd);
                errors++;
            end
            if (commit_value !== val) begin
                $display("CHECK FAILED at %0t: x%0d value %h, expected %h",
                         $time, rd, commit_value, val);
                errors++;
            end
            if (commit_tag !== tag) begin
                $display("CHECK FAILED at %0t: commit tag %0d, expected %0d",
                         $time, commit_tag, tag);
                errors++;
            end
            // x0 retires but never holds a value
            if (rd == 5'd0) begin
                x0_commits++;
            end else begin
                committed_regs[rd] = val;
            end
        end
    endtask

    // one cycle with outputs sampled mid cycle
    task automatic step();
        @(negedge clk);
        if (commit_valid === 1'b1) begin
            check_commit();
        end
    endtask

    task automatic model_accept(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                                input logic [4:0] rs2, input logic [11:0] imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a   = spec_regs[rs1];
        b   = (kind >= 6) ? {{20{imm[11]}}, imm} : spec_regs[rs2];
        res = alu_model(kind, a, b);
        if (rd != 5'd0) begin
            spec_regs[rd] = res;
        end
        exp_rd.push_back(rd);
        exp_val.push_back(res);
        exp_tag.push_back(next_tag);
        // tags run 1..rob_slots-1 and wrap past 0
        if (next_tag == tag_t'(rob_slots - 1)) begin
            next_tag = tag_t'(1);
        end else begin
            next_tag = next_tag + 1'b1;
        end
        accepted++;
    endtask

    task automatic issue(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [11:0] imm);
        bit taken;
        taken       = 1'b0;
        instr       = encode(kind, rd, rs1, rs2, imm);
        instr_valid = 1'b1;
        while (!taken) begin
            // ready only moves on the rising edge
            if (instr_ready === 1'b1) begin
                model_accept(kind, rd, rs1, rs2, imm);
                taken = 1'b1;
            end else begin
                stall_cycles++;
            end
            step();
        end
        instr_valid = 1'b0;
    endtask

    task automatic issue_random(input bit chain, input int gap_max);
        int          kind;
        int          gap;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        kind = rand_below(11);
        // x0..x7 only for lots of reuse
        rd   = 5'(rand_below(8));
        rs1  = 5'(rand_below(8));
        rs2  = 5'(rand_below(8));
        imm  = 12'($random(seed));
        gap  = rand_below(gap_max + 1);
        if (chain) begin
            // serial dependence through x1
            rd  = 5'd1;
            rs1 = 5'd1;
        end
        issue(kind, rd, rs1, rs2, imm);
        repeat (gap) step();
    endtask

    task automatic flush_core();
        instr_valid = 1'b0;
        flush       = 1'b1;
        // in-flight work is lost so the model returns to retired state
        dropped += exp_rd.size();
        exp_rd.delete();
        exp_val.delete();
        exp_tag.delete();
        spec_regs = committed_regs;
        next_tag  = tag_t'(1);
        step();
        flush = 1'b0;
        if (instr_ready !== 1'b1) begin
            $display("CHECK FAILED at %0t: instr_ready=%b after flush, expected 1",
                     $time, instr_ready);
            errors++;
        end
        // any commit here has nothing outstanding and fails in step
        repeat (6) step();
    endtask

    // hard stop
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout, run did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        seed         = 1;
        errors       = 0;
        accepted     = 0;
        committed    = 0;
        dropped      = 0;
        x0_commits   = 0;
        stall_cycles = 0;
        rst          = 1'b1;
        flush        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        next_tag     = tag_t'(1);
        for (int i = 0; i < 32; i++) begin
            spec_regs[i]      = 32'd0;
            committed_regs[i] = 32'd0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        if (instr_ready !== 1'b1 || commit_valid !== 1'b0) begin
            $display("CHECK FAILED at %0t: after reset instr_ready=%b commit_valid=%b, %s",
                     $time, instr_ready, commit_valid, "expected 1 and 0");
            errors++;
        end

        repeat (130) issue_random(1'b0, 3);

        // back to back chain longer than the rob
        stalls_before = stall_cycles;
        repeat (24) issue_random(1'b1, 0);
        if (stall_cycles == stalls_before) begin
            $display("instr_ready never fell during the dependent burst");
            errors++;
        end

        // keep work in flight and then drop it
        repeat (16) issue_random(1'b0, 0);
        flush_core();

        repeat (130) issue_random(1'b0, 3);

        while (exp_rd.size() != 0) begin
            step();
        end
        repeat (8) step();

        if (committed != accepted - dropped) begin
            $display("CHECK FAILED at %0t: %0d commits, expected %0d (%0d accepted, %0d flushed)",
                     $time, committed, accepted - dropped, accepted, dropped);
            errors++;
        end
        if (x0_commits == 0) begin
            $display("no instruction with rd x0 reached commit");
            errors++;
        end
        $display("accepted %0d, committed %0d, flushed %0d, stall cycles %0d, errors %0d",
                 accepted, committed, dropped, stall_cycles, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period_ns = 20
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
    end

    always #(period_ns / 2) clk = ~clk;

endmodule

/* ooo_properties.sv */
`timescale 1ns/1ps

module ooo_properties #(
    parameter int rob_entries = 8
) (
    input logic                         clk,
    input logic                         rst,
    input logic                         flush,
    input logic                         alloc,
    input logic                         full,
    input logic [$clog2(rob_entries):0] count,
    input logic                         commit_valid,
    input ooo_pkg::tag_t                commit_tag
);

    localparam int cnt_w = $clog2(rob_entries) + 1;

    // slot 0 never holds an entry
    count_in_range: assert property (
        @(posedge clk) disable iff (rst) count <= cnt_w'(rob_entries - 1)
    ) else $error("rob count %0d above %0d", count, rob_entries - 1);

    no_alloc_when_full: assert property (
        @(posedge clk) disable iff (rst) !(alloc && full)
    ) else $error("allocation while the rob is full");

    commit_tag_nonzero: assert property (
        @(posedge clk) disable iff (rst) commit_valid |-> commit_tag != '0
    ) else $error("commit with tag 0");

    // pulse killed by either clear
    quiet_after_clear: assert property (
        @(posedge clk) (rst || flush) |=> !commit_valid
    ) else $error("commit_valid high right after reset or flush");

endmodule

bind ro_buffer ooo_properties #(
    .rob_entries (rob_entries)
) i_ooo_properties (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .alloc        (alloc),
    .full         (full),
    .count        (count),
    .commit_valid (commit_valid),
    .commit_tag   (commit_tag)
);

/* ooo_core.sv */
`timescale 1ns/1ps

module ooo_core #(
    parameter int rob_entries = 8,
    parameter int rs_entries  = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   instr_valid,
    input  rv32i_pkg::rv32_instr_t instr,
    output logic                   instr_ready,
    output logic                   commit_valid,
    output ooo_pkg::tag_t          commit_tag,
    output ooo_pkg::reg_idx_t      commit_rd,
    output rv32i_pkg::word_t       commit_value
);
    import ooo_pkg::*;
    import rv32i_pkg::*;

    // dispatch to rob
    logic     alloc;
    tag_t     alloc_tag;
    reg_idx_t alloc_rd;
    logic     rob_full;
    tag_t     lookup_tag_a;
    tag_t     lookup_tag_b;
    logic     lookup_ready_a;
    logic     lookup_ready_b;
    word_t    lookup_value_a;
    word_t    lookup_value_b;

    // dispatch to regfile
    reg_idx_t raddr_a;
    reg_idx_t raddr_b;
    word_t    rdata_a;
    word_t    rdata_b;

    // dispatch to station
    logic     rs_write;
    alu_op_t  rs_op;
    word_t    rs_val_a;
    word_t    rs_val_b;
    tag_t     rs_tag_a;
    tag_t     rs_tag_b;
    tag_t     rs_dest_tag;
    logic     rs_full;

    // common data bus
    logic     cdb_valid;
    tag_t     cdb_tag;
    word_t    cdb_value;

    regfile i_regfile (
        .clk     (clk),
        .rst     (rst),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (commit_valid),
        .waddr   (commit_rd),
        .wdata   (commit_value)
    );

    dispatch #(
        .rob_entries (rob_entries)
    ) i_dispatch (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_ready    (instr_ready),
        .rob_full       (rob_full),
        .rs_full        (rs_full),
        .alloc          (alloc),
        .alloc_tag      (alloc_tag),
        .alloc_rd       (alloc_rd),
        .lookup_tag_a   (lookup_tag_a),
        .lookup_tag_b   (lookup_tag_b),
        .lookup_ready_a (lookup_ready_a),
        .lookup_ready_b (lookup_ready_b),
        .lookup_value_a (lookup_value_a),
        .lookup_value_b (lookup_value_b),
        .raddr_a        (raddr_a),
        .raddr_b        (raddr_b),
        .rdata_a        (rdata_a),
        .rdata_b        (rdata_b),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .rs_write       (rs_write),
        .rs_op          (rs_op),
        .rs_val_a       (rs_val_a),
        .rs_val_b       (rs_val_b),
        .rs_tag_a       (rs_tag_a),
        .rs_tag_b       (rs_tag_b),
        .rs_dest_tag    (rs_dest_tag),
        .commit_valid   (commit_valid),
        .commit_tag     (commit_tag),
        .commit_rd      (commit_rd)
    );

    res_station #(
        .rs_entries (rs_entries)
    ) i_res_station (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .rs_write    (rs_write),
        .rs_op       (rs_op),
        .rs_val_a    (rs_val_a),
        .rs_val_b    (rs_val_b),
        .rs_tag_a    (rs_tag_a),
        .rs_tag_b    (rs_tag_b),
        .rs_dest_tag (rs_dest_tag),
        .rs_full     (rs_full),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value)
    );

    ro_buffer #(
        .rob_entries (rob_entries)
    ) i_ro_buffer (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .alloc          (alloc),
        .alloc_rd       (alloc_rd),
        .alloc_tag      (alloc_tag),
        .full           (rob_full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .lookup_tag_a   (lookup_tag_a),
        .lookup_tag_b   (lookup_tag_b),
        .lookup_ready_a (lookup_ready_a),
        .lookup_ready_b (lookup_ready_b),
        .lookup_value_a (lookup_value_a),
        .lookup_value_b (lookup_value_b),
        .commit_valid   (commit_valid),
        .commit_tag     (commit_tag),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value)
    );

endmodule

/* ro_buffer.sv */
`timescale 1ns/1ps

module ro_buffer #(
    parameter int rob_entries = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              alloc,
    input  ooo_pkg::reg_idx_t alloc_rd,
    output ooo_pkg::tag_t     alloc_tag,
    output logic              full,
    input  logic              cdb_valid,
    input  ooo_pkg::tag_t     cdb_tag,
    input  rv32i_pkg::word_t  cdb_value,
    input  ooo_pkg::tag_t     lookup_tag_a,
    input  ooo_pkg::tag_t     lookup_tag_b,
    output logic              lookup_ready_a,
    output logic              lookup_ready_b,
    output rv32i_pkg::word_t  lookup_value_a,
    output rv32i_pkg::word_t  lookup_value_b,
    output logic              commit_valid,
    output ooo_pkg::tag_t     commit_tag,
    output ooo_pkg::reg_idx_t commit_rd,
    output rv32i_pkg::word_t  commit_value
);
    import ooo_pkg::*;
    import rv32i_pkg::*;

    localparam int ptr_w = $clog2(rob_entries);

    if (rob_entries > (1 << max_tag_bits) || rob_entries < 4) begin : g_size_check
        $error("rob_entries %0d outside 4 to %0d", rob_entries, 1 << max_tag_bits);
    end

    logic             valid [rob_entries];
    logic             done  [rob_entries];
    reg_idx_t         rd    [rob_entries];
    word_t            value [rob_entries];
    logic [ptr_w-1:0] head;
    logic [ptr_w-1:0] tail;
    logic [ptr_w:0]   count;
    logic             head_done;

    // wrap skips reserved slot 0
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(rob_entries - 1)) ? ptr_w'(1) : p + 1'b1;
    endfunction

    assign full      = count == (ptr_w + 1)'(rob_entries - 1);
    assign alloc_tag = tag_t'(tail);
    assign head_done = valid[head] && done[head];

    // done outlives commit so operand lookup still hits during the commit pulse
    assign lookup_ready_a = done[lookup_tag_a[ptr_w-1:0]];
    assign lookup_ready_b = done[lookup_tag_b[ptr_w-1:0]];
    assign lookup_value_a = value[lookup_tag_a[ptr_w-1:0]];
    assign lookup_value_b = value[lookup_tag_b[ptr_w-1:0]];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < rob_entries; i++) begin
                valid[i] <= 1'b0;
                done[i]  <= 1'b0;
            end
            head         <= ptr_w'(1);
            tail         <= ptr_w'(1);
            count        <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= head_done;
            // results land by tag
            if (cdb_valid) begin
                done[cdb_tag[ptr_w-1:0]] <= 1'b1;
            end
            // retire head, one per cycle
            if (head_done) begin
                valid[head] <= 1'b0;
                head        <= next_ptr(head);
            end
            // allocation runs alongside commit
            if (alloc) begin
                valid[tail] <= 1'b1;
                done[tail]  <= 1'b0;
                tail        <= next_ptr(tail);
            end
            count <= count + (ptr_w + 1)'(alloc) - (ptr_w + 1)'(head_done);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rd[tail] <= alloc_rd;
        end
        if (cdb_valid) begin
            value[cdb_tag[ptr_w-1:0]] <= cdb_value;
        end
        // registered commit record
        if (head_done) begin
            commit_tag   <= tag_t'(head);
            commit_rd    <= rd[head];
            commit_value <= value[head];
        end
    end

endmodule

/* res_station.sv */
`timescale 1ns/1ps

module res_station #(
    parameter int rs_entries = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               rs_write,
    input  rv32i_pkg::alu_op_t rs_op,
    input  rv32i_pkg::word_t   rs_val_a,
    input  rv32i_pkg::word_t   rs_val_b,
    input  ooo_pkg::tag_t      rs_tag_a,
    input  ooo_pkg::tag_t      rs_tag_b,
    input  ooo_pkg::tag_t      rs_dest_tag,
    output logic               rs_full,
    output logic               cdb_valid,
    output ooo_pkg::tag_t      cdb_tag,
    output rv32i_pkg::word_t   cdb_value
);
    import ooo_pkg::*;
    import rv32i_pkg::*;

    localparam int idx_w = (rs_entries > 1) ? $clog2(rs_entries) : 1;

    logic             busy  [rs_entries];
    alu_op_t          op    [rs_entries];
    word_t            val_a [rs_entries];
    word_t            val_b [rs_entries];
    tag_t             tag_a [rs_entries];
    tag_t             tag_b [rs_entries];
    tag_t             dest  [rs_entries];
    logic             free_found;
    logic             sel_found;
    logic [idx_w-1:0] free_idx;
    logic [idx_w-1:0] sel_idx;
    word_t            opa;
    word_t            opb;
    word_t            result;

    // lowest free slot and lowest slot with both operands
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        sel_found  = 1'b0;
        sel_idx    = '0;
        for (int i = rs_entries - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_found = 1'b1;
                free_idx   = idx_w'(i);
            end
            if (busy[i] && tag_a[i] == no_tag && tag_b[i] == no_tag) begin
                sel_found = 1'b1;
                sel_idx   = idx_w'(i);
            end
        end
    end

    assign rs_full = !free_found;

    // alu on the selected slot
    assign opa = val_a[sel_idx];
    assign opb = val_b[sel_idx];

    always_comb begin
        case (op[sel_idx])
            alu_add: result = opa + opb;
            alu_sub: result = opa - opb;
            alu_and: result = opa & opb;
            alu_or:  result = opa | opb;
            alu_xor: result = opa ^ opb;
            alu_slt: result = {31'b0, $signed(opa) < $signed(opb)};
            default: result = opa + opb;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < rs_entries; i++) begin
                busy[i] <= 1'b0;
            end
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= sel_found;
            if (sel_found) begin
                busy[sel_idx] <= 1'b0;
            end
            // never the selected slot, that one is busy
            if (rs_write && free_found) begin
                busy[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // snoop our own broadcast, a valid cdb tag is never no_tag
        for (int i = 0; i < rs_entries; i++) begin
            if (cdb_valid && tag_a[i] == cdb_tag) begin
                val_a[i] <= cdb_value;
                tag_a[i] <= no_tag;
            end
            if (cdb_valid && tag_b[i] == cdb_tag) begin
                val_b[i] <= cdb_value;
                tag_b[i] <= no_tag;
            end
        end
        // new entry overrides any stale snoop of a free slot
        if (rs_write && free_found) begin
            op[free_idx]    <= rs_op;
            val_a[free_idx] <= rs_val_a;
            val_b[free_idx] <= rs_val_b;
            tag_a[free_idx] <= rs_tag_a;
            tag_b[free_idx] <= rs_tag_b;
            dest[free_idx]  <= rs_dest_tag;
        end
        if (sel_found) begin
            cdb_tag   <= dest[sel_idx];
            cdb_value <= result;
        end
    end

endmodule

/* dispatch.sv */
`timescale 1ns/1ps

module dispatch #(
    parameter int rob_entries = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  instr_valid,
    input  rv32i_pkg::rv32_instr_t instr,
    output logic                  instr_ready,
    input  logic                  rob_full,
    input  logic                  rs_full,
    output logic                  alloc,
    input  ooo_pkg::tag_t         alloc_tag,
    output ooo_pkg::reg_idx_t     alloc_rd,
    output ooo_pkg::tag_t         lookup_tag_a,
    output ooo_pkg::tag_t         lookup_tag_b,
    input  logic                  lookup_ready_a,
    input  logic                  lookup_ready_b,
    input  rv32i_pkg::word_t      lookup_value_a,
    input  rv32i_pkg::word_t      lookup_value_b,
    output ooo_pkg::reg_idx_t     raddr_a,
    output ooo_pkg::reg_idx_t     raddr_b,
    input  rv32i_pkg::word_t      rdata_a,
    input  rv32i_pkg::word_t      rdata_b,
    input  logic                  cdb_valid,
    input  ooo_pkg::tag_t         cdb_tag,
    input  rv32i_pkg::word_t      cdb_value,
    output logic                  rs_write,
    output rv32i_pkg::alu_op_t    rs_op,
    output rv32i_pkg::word_t      rs_val_a,
    output rv32i_pkg::word_t      rs_val_b,
    output ooo_pkg::tag_t         rs_tag_a,
    output ooo_pkg::tag_t         rs_tag_b,
    output ooo_pkg::tag_t         rs_dest_tag,
    input  logic                  commit_valid,
    input  ooo_pkg::tag_t         commit_tag,
    input  ooo_pkg::reg_idx_t     commit_rd
);
    import ooo_pkg::*;
    import rv32i_pkg::*;

    if (rob_entries > (1 << max_tag_bits)) begin : g_tag_check
        $error("rob_entries %0d needs more than %0d tag bits", rob_entries, max_tag_bits);
    end

    // youngest in-flight writer per register, no_tag when the regfile is current
    tag_t     rename [num_regs];
    opcode_t  opcode;
    logic     is_reg;
    logic     is_imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;

    // issue handshake
    assign instr_ready = !rob_full && !rs_full;
    assign alloc       = instr_valid && instr_ready;
    assign rs_write    = alloc;
    assign rs_dest_tag = alloc_tag;
    assign alloc_rd    = rd;

    // opcode and immediate from the i view, registers from the r view
    assign opcode = opcode_t'(instr.i.opcode);
    assign is_reg = opcode == op_reg;
    assign is_imm = opcode == op_imm;
    assign rs1    = instr.r.rs1;
    assign rs2    = instr.r.rs2;
    assign rd     = instr.r.rd;
    assign imm    = {{20{instr.i.imm[11]}}, instr.i.imm};

    always_comb begin
        case (instr.r.funct3)
            // funct7 only meaningful for the register form
            f3_add:  rs_op = (is_reg && instr.r.funct7 == f7_sub) ? alu_sub : alu_add;
            f3_slt:  rs_op = alu_slt;
            f3_xor:  rs_op = alu_xor;
            f3_or:   rs_op = alu_or;
            f3_and:  rs_op = alu_and;
            default: rs_op = alu_add;
        endcase
    end

    assign raddr_a      = rs1;
    assign raddr_b      = rs2;
    assign lookup_tag_a = rename[rs1];
    assign lookup_tag_b = rename[rs2];

    // regfile, then finished rob entry, then a result on the bus right now
    function automatic void resolve(
        input  tag_t  src_tag,
        input  word_t rf_val,
        input  logic  rob_rdy,
        input  word_t rob_val,
        output tag_t  tag_out,
        output word_t val_out
    );
        if (src_tag == no_tag) begin
            tag_out = no_tag;
            val_out = rf_val;
        end else if (rob_rdy) begin
            tag_out = no_tag;
            val_out = rob_val;
        end else if (cdb_valid && cdb_tag == src_tag) begin
            tag_out = no_tag;
            val_out = cdb_value;
        end else begin
            // still waiting, the station snoops for it
            tag_out = src_tag;
            val_out = '0;
        end
    endfunction

    always_comb begin
        resolve(lookup_tag_a, rdata_a, lookup_ready_a, lookup_value_a, rs_tag_a, rs_val_a);
        resolve(lookup_tag_b, rdata_b, lookup_ready_b, lookup_value_b, rs_tag_b, rs_val_b);
        if (is_imm) begin
            rs_tag_b = no_tag;
            rs_val_b = imm;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < num_regs; i++) begin
                rename[i] <= no_tag;
            end
        end else begin
            // drop the mapping once its writer has retired
            if (commit_valid && rename[commit_rd] == commit_tag) begin
                rename[commit_rd] <= no_tag;
            end
            // a new writer of the same register wins over the clear
            if (alloc && rd != '0) begin
                rename[rd] <= alloc_tag;
            end
        end
    end

endmodule

/* regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  logic              rst,
    input  ooo_pkg::reg_idx_t raddr_a,
    input  ooo_pkg::reg_idx_t raddr_b,
    output rv32i_pkg::word_t  rdata_a,
    output rv32i_pkg::word_t  rdata_b,
    input  logic              we,
    input  ooo_pkg::reg_idx_t waddr,
    input  rv32i_pkg::word_t  wdata
);
    import ooo_pkg::*;
    import rv32i_pkg::*;

    word_t regs [num_regs];

    // no write bypass, the rename table still holds the tag
    // until the commit edge
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

endmodule

/* ooo_pkg.sv */
package ooo_pkg;

    // widest tag a port can carry, bounds rob_entries at 16
    localparam int max_tag_bits = 4;

    typedef logic [max_tag_bits-1:0] tag_t;

    // slot 0 of the rob is never allocated
    localparam tag_t no_tag = '0;

    typedef logic [4:0] reg_idx_t;

    localparam int num_regs = 32;

endpackage

/* rv32i_pkg.sv */
package rv32i_pkg;

    typedef logic [31:0] word_t;

    // major opcodes of the supported alu instructions
    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011
    } opcode_t;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // funct7 of sub, add uses all zeros
    localparam logic [6:0] f7_sub = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // one instruction word, two field layouts
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } rv32_instr_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_t;

endpackage
